//--- compile.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/mem_bus_if.sv
verilog/bus_unit.sv
verilog/instruction_decode.sv
verilog/alu.sv
verilog/datapath.sv
verilog/cpu6502_top.sv
tests/tb_memory_model.sv
tests/tb_cpu6502.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_cpu6502 -o sim_cpu6502

output="$(./obj_dir/sim_cpu6502 2>&1 || true)"
echo "$output"

grep -q "^Simulation completed successfully$" <<< "$output"

//--- tests/tb_cpu6502.sv
`include "cpu_settings.svh"

module tb_cpu6502;

  localparam int NROWS = 12;
  localparam int CYCLE_LIMIT = NROWS * 200;
  localparam logic [15:0] RES_ADDR = 16'h0200;
  localparam logic [15:0] CARRY_ADDR = 16'h0201;
  localparam logic [15:0] POISON_ADDR = 16'h0202; // Only a skipped STA points here

  typedef struct packed {
    logic [7:0] op;
    logic cin;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] res;
    logic c;
    logic jmp; // Jump over a store to POISON_ADDR
  } row_t;

  logic clk_cpu;
  logic rst_n;
  logic [15:0] mem_addr;
  logic [7:0] mem_wdata;
  logic [7:0] mem_rdata;
  logic mem_we;
  logic mem_req;
  logic mem_ready;
  logic halted;

  row_t rows [0:NROWS-1];
  logic [15:0] wr_ptr; // Next program byte
  logic [15:0] brk_addr;
  int cycles;

  cpu6502_top DUT (.*);
  tb_memory_model mem_i (.*);

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got == exp) else begin
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic put(input logic [7:0] val);
    mem_i.mem[wr_ptr] = val;
    wr_ptr = wr_ptr + 16'd1;
  endtask

  task automatic put_abs(input logic [7:0] op, input logic [15:0] addr);
    put(op);
    put(addr[7:0]); // Low byte first
    put(addr[15:8]);
  endtask

  function automatic bit is_inc(input logic [7:0] op);
    return op == cpu_pkg::OP_INX || op == cpu_pkg::OP_INY;
  endfunction

  task automatic build_program(input row_t r);
    logic [15:0] target;
    wr_ptr = `CPU_START_PC;
    put(r.cin ? cpu_pkg::OP_SEC : cpu_pkg::OP_CLC);
    if (is_inc(r.op)) begin
      put(r.op == cpu_pkg::OP_INX ? cpu_pkg::OP_LDX_IMM : cpu_pkg::OP_LDY_IMM);
      put(r.a);
      put(r.op);
    end else begin
      put(cpu_pkg::OP_LDA_IMM);
      put(r.a);
      put(r.op);
      put(r.b);
    end
    if (r.jmp) begin
      target = wr_ptr + 16'd6; // Past the JMP and the poisoned STA
      put_abs(cpu_pkg::OP_JMP_ABS, target);
      put_abs(cpu_pkg::OP_STA_ABS, POISON_ADDR);
    end
    if (!is_inc(r.op)) begin
      put_abs(cpu_pkg::OP_STA_ABS, RES_ADDR);
    end
    put(cpu_pkg::OP_LDA_IMM);
    put(8'h00);
    put(cpu_pkg::OP_ADC_IMM);
    put(8'h00); // A becomes the carry flag
    put_abs(cpu_pkg::OP_STA_ABS, CARRY_ADDR);
    brk_addr = wr_ptr;
    put(cpu_pkg::OP_BRK);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(negedge clk_cpu);
    rst_n = 1'b1;
  endtask

  task automatic check_results(input row_t r);
    int idx;
    idx = 0;
    if (r.op == cpu_pkg::OP_INX) begin
      check_value("x register", 16'(DUT.u_datapath.x_q), 16'(r.res));
    end else if (r.op == cpu_pkg::OP_INY) begin
      check_value("y register", 16'(DUT.u_datapath.y_q), 16'(r.res));
    end else begin
      check_value("mem_addr of result store", mem_i.wr_addr[0], RES_ADDR);
      check_value("mem_wdata of result store", 16'(mem_i.wr_data[0]), 16'(r.res));
      idx = 1;
    end
    check_value("mem_addr of carry store", mem_i.wr_addr[idx], CARRY_ADDR);
    check_value("mem_wdata of carry store", 16'(mem_i.wr_data[idx]), 16'(r.c));
    check_value("number of writes", 16'(mem_i.wr_count), 16'(idx + 1));
  endtask

  initial begin
    clk_cpu = 1'b0;
    forever #2 clk_cpu = ~clk_cpu;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_cpu);
      cycles++;
    end
    $display("Timeout: the programs did not all halt within %0d cycles", CYCLE_LIMIT);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  initial begin
    rst_n = 1'b0;
    // op, carry in, a, b, result, carry out, jump
    rows[0] = '{cpu_pkg::OP_ADC_IMM, 1'b0, 8'h10, 8'h20, 8'h30, 1'b0, 1'b0};
    rows[1] = '{cpu_pkg::OP_ADC_IMM, 1'b1, 8'hFF, 8'h00, 8'h00, 1'b1, 1'b0}; // Wraps to 00
    rows[2] = '{cpu_pkg::OP_ADC_IMM, 1'b0, 8'h80, 8'h80, 8'h00, 1'b1, 1'b0};
    rows[3] = '{cpu_pkg::OP_SBC_IMM, 1'b1, 8'h50, 8'h30, 8'h20, 1'b1, 1'b0};
    rows[4] = '{cpu_pkg::OP_SBC_IMM, 1'b0, 8'h50, 8'h30, 8'h1F, 1'b1, 1'b0}; // Borrow in
    rows[5] = '{cpu_pkg::OP_SBC_IMM, 1'b1, 8'h00, 8'h01, 8'hFF, 1'b0, 1'b0}; // Borrow out
    rows[6] = '{cpu_pkg::OP_AND_IMM, 1'b1, 8'hF0, 8'h3C, 8'h30, 1'b1, 1'b0};
    rows[7] = '{cpu_pkg::OP_ORA_IMM, 1'b0, 8'h0F, 8'hA0, 8'hAF, 1'b0, 1'b0};
    rows[8] = '{cpu_pkg::OP_EOR_IMM, 1'b1, 8'hFF, 8'h5A, 8'hA5, 1'b1, 1'b0};
    rows[9] = '{cpu_pkg::OP_INX, 1'b0, 8'hFF, 8'h00, 8'h00, 1'b0, 1'b0};
    rows[10] = '{cpu_pkg::OP_INY, 1'b1, 8'h7F, 8'h00, 8'h80, 1'b1, 1'b0};
    rows[11] = '{cpu_pkg::OP_ADC_IMM, 1'b0, 8'h01, 8'h02, 8'h03, 1'b0, 1'b1};
    for (int i = 0; i < NROWS; i++) begin
      mem_i.clear();
      build_program(rows[i]);
      apply_reset();
      while (mem_req !== 1'b1) @(negedge clk_cpu);
      check_value("mem_addr of first fetch", mem_addr, `CPU_START_PC);
      check_value("mem_we of first fetch", 16'(mem_we), 16'h0000);
      while (halted !== 1'b1) @(negedge clk_cpu);
      check_value("last read address", mem_i.last_rd_addr, brk_addr); // BRK ended it
      check_results(rows[i]);
      repeat (8) begin
        @(negedge clk_cpu);
        check_value("mem_req after halt", 16'(mem_req), 16'h0000);
        check_value("halted", 16'(halted), 16'h0001);
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- tests/tb_memory_model.sv
module tb_memory_model (
  input  logic        clk_cpu,
  input  logic [15:0] mem_addr,
  input  logic [7:0]  mem_wdata,
  input  logic        mem_we,
  input  logic        mem_req,
  output logic [7:0]  mem_rdata,
  output logic        mem_ready
);

  logic [7:0] mem [0:65535];
  logic [15:0] wr_addr [0:7]; // Write log in order of acceptance
  logic [7:0] wr_data [0:7];
  logic [15:0] last_rd_addr; // Address of the last completed read
  int wr_count;
  int wait_left;
  int seed = 90284;
  bit pending; // Wait cycles already drawn for this request

  task automatic clear();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'h00; // Stray fetches hit BRK
    end
    wr_count = 0;
  endtask

  initial begin
    mem_ready = 1'b0;
    mem_rdata = 8'h00;
    pending = 1'b0;
    wait_left = 0;
    last_rd_addr = 16'h0000;
  end

  // All memory responses change on the falling edge
  always @(negedge clk_cpu) begin
    if (mem_ready) begin
      mem_ready = 1'b0; // Accepted on the last rising edge
    end else if (mem_req === 1'b1) begin
      if (!pending) begin
        pending = 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
      end
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        pending = 1'b0;
        mem_ready = 1'b1;
        if (mem_we) begin
          mem[mem_addr] = mem_wdata;
          wr_addr[wr_count[2:0]] = mem_addr;
          wr_data[wr_count[2:0]] = mem_wdata;
          wr_count++;
        end else begin
          mem_rdata = mem[mem_addr];
          last_rd_addr = mem_addr;
        end
      end
    end
  end

endmodule

//--- verilog/cpu6502_top.sv
`include "cpu_settings.svh"

module cpu6502_top (
  input  logic                   clk_cpu,
  input  logic                   rst_n,
  output logic [`CPU_ADDR_W-1:0] mem_addr,
  output logic [`CPU_DATA_W-1:0] mem_wdata,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  output logic                   mem_we,
  output logic                   mem_req,
  input  logic                   mem_ready,
  output logic                   halted
);

  mem_bus_if bus_i ();

  cpu_pkg::ctrl_t ctrl;
  cpu_pkg::flags_t flags;
  cpu_pkg::flags_t alu_flags;
  cpu_pkg::alu_op_e alu_op;
  logic [7:0] opcode;
  logic [`CPU_DATA_W-1:0] alu_a;
  logic [`CPU_DATA_W-1:0] alu_b;
  logic [`CPU_DATA_W-1:0] alu_y;
  logic alu_cin;

  instruction_decode u_decode (
    .clk_cpu (clk_cpu),
    .rst_n   (rst_n),
    .opcode  (opcode),
    .flags   (flags),
    .ctrl    (ctrl),
    .bus     (bus_i.ctrl),
    .halted  (halted)
  );

  datapath u_datapath (
    .clk_cpu   (clk_cpu),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .bus       (bus_i.data),
    .opcode    (opcode),
    .flags     (flags),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_op    (alu_op),
    .alu_cin   (alu_cin),
    .alu_y     (alu_y),
    .alu_flags (alu_flags)
  );

  alu u_alu (
    .clk_cpu (clk_cpu),
    .op      (alu_op),
    .a       (alu_a),
    .b       (alu_b),
    .cin     (alu_cin),
    .y       (alu_y),
    .flags   (alu_flags)
  );

  bus_unit u_bus (
    .clk_cpu   (clk_cpu),
    .rst_n     (rst_n),
    .bus       (bus_i.bus),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_we    (mem_we),
    .mem_req   (mem_req),
    .mem_ready (mem_ready)
  );

endmodule

//--- verilog/datapath.sv
`include "cpu_settings.svh"

module datapath (
  input  logic                   clk_cpu,
  input  logic                   rst_n,
  input  cpu_pkg::ctrl_t         ctrl,
  mem_bus_if.data                bus,
  output logic [7:0]             opcode,
  output cpu_pkg::flags_t        flags,
  output logic [`CPU_DATA_W-1:0] alu_a,
  output logic [`CPU_DATA_W-1:0] alu_b,
  output cpu_pkg::alu_op_e       alu_op,
  output logic                   alu_cin,
  input  logic [`CPU_DATA_W-1:0] alu_y,
  input  cpu_pkg::flags_t        alu_flags
);

  logic [`CPU_DATA_W-1:0] a_q;
  logic [`CPU_DATA_W-1:0] x_q;
  logic [`CPU_DATA_W-1:0] y_q;
  logic [7:0] ir_q;
  logic [`CPU_ADDR_W-1:0] pc_q;
  logic [`CPU_ADDR_W-1:0] lat_q; // Absolute address from the operand bytes
  logic [`CPU_ADDR_W-1:0] lat_nxt;
  cpu_pkg::flags_t flags_q;

  // Latch value including the byte arriving this cycle, so JMP loads PC directly
  assign lat_nxt = {ctrl.lat_hi ? bus.rdata : lat_q[`CPU_ADDR_W-1:8],
                    ctrl.lat_lo ? bus.rdata : lat_q[7:0]};

  always_comb begin
    if (ctrl.src_x) begin
      alu_a = x_q;
    end else if (ctrl.src_y) begin
      alu_a = y_q;
    end else if (ctrl.src_m) begin
      alu_a = bus.rdata; // Immediate loads
    end else begin
      alu_a = a_q;
    end
  end

  assign alu_b = bus.rdata;
  assign alu_op = ctrl.alu_op;
  assign alu_cin = flags_q.c;

  assign bus.addr = bus.we ? lat_q : pc_q; // Stores go to the latched address
  assign bus.wdata = a_q;
  assign opcode = ir_q;
  assign flags = flags_q;

  always_ff @(posedge clk_cpu) begin
    if (!rst_n) begin
      a_q <= '0;
      x_q <= '0;
      y_q <= '0;
      pc_q <= `CPU_START_PC;
      flags_q <= '0;
    end else begin
      if (ctrl.load_a) a_q <= alu_y;
      if (ctrl.load_x) x_q <= alu_y;
      if (ctrl.load_y) y_q <= alu_y;
      if (ctrl.pc_load) begin
        pc_q <= lat_nxt;
      end else if (ctrl.pc_inc) begin
        pc_q <= pc_q + 1'b1;
      end
      if (ctrl.upd_nz) begin
        flags_q.n <= alu_flags.n;
        flags_q.z <= alu_flags.z;
      end
      if (ctrl.upd_cv) begin
        flags_q.c <= alu_flags.c;
        flags_q.v <= alu_flags.v;
      end else if (ctrl.set_c) begin
        flags_q.c <= 1'b1;
      end else if (ctrl.clr_c) begin
        flags_q.c <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (ctrl.ir_load) ir_q <= bus.rdata;
    lat_q <= lat_nxt;
  end

endmodule

//--- verilog/alu.sv
`include "cpu_settings.svh"

module alu (
  input  logic                   clk_cpu,
  input  cpu_pkg::alu_op_e       op,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  logic                   cin,
  output logic [`CPU_DATA_W-1:0] y,
  output cpu_pkg::flags_t        flags
);

  logic [`CPU_DATA_W-1:0] b_eff; // Inverted for subtract
  logic [`CPU_DATA_W:0] sum;

  assign b_eff = (op == cpu_pkg::ALU_SUB) ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, cin};

  always_comb begin
    flags.c = 1'b0;
    flags.v = 1'b0;
    case (op)
      cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: begin
        y = sum[`CPU_DATA_W-1:0];
        flags.c = sum[`CPU_DATA_W]; // For SUB, set means no borrow
        flags.v = (a[`CPU_DATA_W-1] == b_eff[`CPU_DATA_W-1]) &&
                  (y[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
      end
      cpu_pkg::ALU_AND: y = a & b;
      cpu_pkg::ALU_OR: y = a | b;
      cpu_pkg::ALU_XOR: y = a ^ b;
      cpu_pkg::ALU_INC: y = a + 1'b1; // Wraps FF to 00
      default: y = a;
    endcase
    flags.n = y[`CPU_DATA_W-1];
    flags.z = (y == '0);
  end

  // Only defined operations reach the ALU
  assert property (@(posedge clk_cpu)
    op inside {cpu_pkg::ALU_PASS, cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_AND,
               cpu_pkg::ALU_OR, cpu_pkg::ALU_XOR, cpu_pkg::ALU_INC})
  else $error("alu: invalid operation %0d", op);

endmodule

//--- verilog/instruction_decode.sv
module instruction_decode (
  input  logic               clk_cpu,
  input  logic               rst_n,
  input  logic [7:0]         opcode,
  input  cpu_pkg::flags_t    flags,
  output cpu_pkg::ctrl_t     ctrl,
  mem_bus_if.ctrl            bus,
  output logic               halted
);

  cpu_pkg::dec_state_e state;
  cpu_pkg::dec_state_e state_nxt;

  always_comb begin
    ctrl = '0;
    state_nxt = state;
    bus.req = 1'b0;
    bus.we = 1'b0;
    case (state)
      cpu_pkg::ST_FETCH: begin
        bus.req = !bus.done;
        if (bus.done) begin
          ctrl.ir_load = 1'b1;
          ctrl.pc_inc = 1'b1;
          state_nxt = cpu_pkg::ST_EXEC;
        end
      end
      cpu_pkg::ST_EXEC: begin
        state_nxt = cpu_pkg::ST_FETCH; // Implied ops finish in this cycle
        case (opcode)
          cpu_pkg::OP_INX: begin
            ctrl.alu_op = cpu_pkg::ALU_INC;
            ctrl.src_x = 1'b1;
            ctrl.load_x = 1'b1;
            ctrl.upd_nz = 1'b1;
          end
          cpu_pkg::OP_INY: begin
            ctrl.alu_op = cpu_pkg::ALU_INC;
            ctrl.src_y = 1'b1;
            ctrl.load_y = 1'b1;
            ctrl.upd_nz = 1'b1;
          end
          cpu_pkg::OP_TAX: begin
            ctrl.load_x = 1'b1; // Pass of A
            ctrl.upd_nz = 1'b1;
          end
          cpu_pkg::OP_CLC: ctrl.clr_c = 1'b1;
          cpu_pkg::OP_SEC: ctrl.set_c = 1'b1;
          cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM,
          cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM, cpu_pkg::OP_AND_IMM,
          cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_EOR_IMM: state_nxt = cpu_pkg::ST_OPERAND;
          cpu_pkg::OP_STA_ABS, cpu_pkg::OP_JMP_ABS: state_nxt = cpu_pkg::ST_ADDR_LO;
          default: state_nxt = cpu_pkg::ST_HALT; // BRK and unknown opcodes
        endcase
      end
      cpu_pkg::ST_OPERAND: begin
        bus.req = !bus.done;
        if (bus.done) begin
          ctrl.pc_inc = 1'b1;
          ctrl.upd_nz = 1'b1;
          state_nxt = cpu_pkg::ST_FETCH;
          case (opcode)
            cpu_pkg::OP_LDA_IMM: {ctrl.src_m, ctrl.load_a} = 2'b11;
            cpu_pkg::OP_LDX_IMM: {ctrl.src_m, ctrl.load_x} = 2'b11;
            cpu_pkg::OP_LDY_IMM: {ctrl.src_m, ctrl.load_y} = 2'b11;
            cpu_pkg::OP_ADC_IMM: ctrl.alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SBC_IMM: ctrl.alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND_IMM: ctrl.alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_ORA_IMM: ctrl.alu_op = cpu_pkg::ALU_OR;
            default: ctrl.alu_op = cpu_pkg::ALU_XOR;
          endcase
          if (opcode == cpu_pkg::OP_ADC_IMM || opcode == cpu_pkg::OP_SBC_IMM) begin
            ctrl.upd_cv = 1'b1;
          end
          if (!ctrl.src_m) begin
            ctrl.load_a = 1'b1; // Logic and arithmetic ops write A
          end
        end
      end
      cpu_pkg::ST_ADDR_LO: begin
        bus.req = !bus.done;
        if (bus.done) begin
          ctrl.lat_lo = 1'b1;
          ctrl.pc_inc = 1'b1;
          state_nxt = cpu_pkg::ST_ADDR_HI;
        end
      end
      cpu_pkg::ST_ADDR_HI: begin
        bus.req = !bus.done;
        if (bus.done) begin
          ctrl.lat_hi = 1'b1;
          if (opcode == cpu_pkg::OP_JMP_ABS) begin
            ctrl.pc_load = 1'b1;
            state_nxt = cpu_pkg::ST_FETCH;
          end else begin
            ctrl.pc_inc = 1'b1;
            state_nxt = cpu_pkg::ST_STORE;
          end
        end
      end
      cpu_pkg::ST_STORE: begin
        bus.req = !bus.done;
        bus.we = 1'b1;
        if (bus.done) begin
          state_nxt = cpu_pkg::ST_FETCH;
        end
      end
      default: state_nxt = cpu_pkg::ST_HALT;
    endcase
  end

  always_ff @(posedge clk_cpu) begin
    if (!rst_n) begin
      state <= cpu_pkg::ST_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  assign halted = (state == cpu_pkg::ST_HALT);

  assert property (@(posedge clk_cpu) disable iff (!rst_n)
    state == cpu_pkg::ST_HALT |-> !bus.req)
  else $error("instruction_decode: request issued after halt");

  // SEC and CLC must reach the datapath carry by the next cycle
  assert property (@(posedge clk_cpu) disable iff (!rst_n)
    state == cpu_pkg::ST_EXEC && (opcode == cpu_pkg::OP_SEC || opcode == cpu_pkg::OP_CLC)
    |=> flags.c == (opcode == cpu_pkg::OP_SEC))
  else $error("instruction_decode: carry flag not updated by SEC/CLC");

endmodule

//--- verilog/bus_unit.sv
`include "cpu_settings.svh"

module bus_unit (
  input  logic                   clk_cpu,
  input  logic                   rst_n,
  mem_bus_if.bus                 bus,
  output logic [`CPU_ADDR_W-1:0] mem_addr,
  output logic [`CPU_DATA_W-1:0] mem_wdata,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  output logic                   mem_we,
  output logic                   mem_req,
  input  logic                   mem_ready
);

  logic busy; // A transfer is out on the external bus
  logic take; // Idle and a new request arrives
  logic finish; // Memory accepts on this edge

  assign take = !busy && bus.req;
  assign finish = busy && mem_ready;
  assign mem_req = busy;

  always_ff @(posedge clk_cpu) begin
    if (!rst_n) begin
      busy <= 1'b0;
      mem_we <= 1'b0;
      bus.done <= 1'b0;
    end else begin
      bus.done <= finish; // One cycle pulse after acceptance
      if (take) begin
        busy <= 1'b1;
        mem_we <= bus.we;
      end else if (finish) begin
        busy <= 1'b0;
        mem_we <= 1'b0;
      end
    end
  end

  // Address and data held from request until accept
  always_ff @(posedge clk_cpu) begin
    if (take) begin
      mem_addr <= bus.addr;
      mem_wdata <= bus.wdata;
    end
    if (finish) begin
      bus.rdata <= mem_rdata; // Captured in the ready cycle
    end
  end

  // External request must not change while the memory stalls it
  assert property (@(posedge clk_cpu) disable iff (!rst_n)
    mem_req && !mem_ready |=> $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
  else $error("bus_unit: request changed while waiting for mem_ready");

endmodule

//--- verilog/mem_bus_if.sv
`include "cpu_settings.svh"

interface mem_bus_if;
  logic req; // Held by the decoder until done
  logic we;
  logic [`CPU_ADDR_W-1:0] addr;
  logic [`CPU_DATA_W-1:0] wdata;
  logic [`CPU_DATA_W-1:0] rdata; // Valid while done is high
  logic done;

  modport ctrl (
    output req,
    output we,
    input done
  );

  // The datapath needs we to pick the store address
  modport data (
    output addr,
    output wdata,
    input rdata,
    input we
  );

  modport bus (
    input req,
    input we,
    input addr,
    input wdata,
    output rdata,
    output done
  );
endinterface

//--- verilog/cpu_pkg.sv
package cpu_pkg;

  // Standard 6502 encodings of the supported subset
  localparam logic [7:0] OP_LDA_IMM = 8'hA9;
  localparam logic [7:0] OP_LDX_IMM = 8'hA2;
  localparam logic [7:0] OP_LDY_IMM = 8'hA0;
  localparam logic [7:0] OP_ADC_IMM = 8'h69;
  localparam logic [7:0] OP_SBC_IMM = 8'hE9;
  localparam logic [7:0] OP_AND_IMM = 8'h29;
  localparam logic [7:0] OP_ORA_IMM = 8'h09;
  localparam logic [7:0] OP_EOR_IMM = 8'h49;
  localparam logic [7:0] OP_STA_ABS = 8'h8D;
  localparam logic [7:0] OP_INX = 8'hE8;
  localparam logic [7:0] OP_INY = 8'hC8;
  localparam logic [7:0] OP_TAX = 8'hAA;
  localparam logic [7:0] OP_CLC = 8'h18;
  localparam logic [7:0] OP_SEC = 8'h38;
  localparam logic [7:0] OP_JMP_ABS = 8'h4C;
  localparam logic [7:0] OP_BRK = 8'h00;

  typedef enum logic [2:0] {
    ALU_PASS, // Operand A unchanged
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_INC
  } alu_op_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_OPERAND,
    ST_ADDR_LO,
    ST_ADDR_HI,
    ST_STORE,
    ST_EXEC, // Opcode decoded, implied ops finish here
    ST_HALT
  } dec_state_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    alu_op_e alu_op;
    logic load_a; // ALU result into A
    logic load_x;
    logic load_y;
    logic src_x; // Operand A is X
    logic src_y; // Operand A is Y
    logic src_m; // Operand A is the read byte
    logic upd_nz;
    logic upd_cv;
    logic set_c;
    logic clr_c;
    logic pc_inc;
    logic pc_load; // PC from the address latch
    logic lat_lo;
    logic lat_hi;
    logic ir_load; // Read byte into the opcode register
  } ctrl_t;

endpackage

//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Address of the first instruction fetch after reset
`define CPU_START_PC 16'h0400

`define CPU_ADDR_W 16 // Memory address bus
`define CPU_DATA_W 8 // Memory data bus and register width

`endif
